// File: design/vs_pkg.sv
package vs_pkg;

	////////////////////////////////////////
	// fixed point and screen constants
	////////////////////////////////////////
	localparam int FIX_W       = 16;	// q8.8 word
	localparam int FRAC_BITS   = 8;
	localparam int NDC_FRAC    = 14;	// q2.14 ndc
	localparam int SCR_W       = 20;	// screen coordinate width
	localparam int HALF_W      = 320;	// 640 wide screen
	localparam int HALF_H      = 240;	// 480 high screen
	localparam int NUM_VERTS   = 4;
	localparam int VERT_W      = $clog2(NUM_VERTS);
	localparam int DIV_CYCLES  = 32;	// one quotient bit per cycle
	localparam int DOT_LATENCY = 3;

	typedef logic signed [FIX_W-1:0] fix_t;

	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);	// 1.0 in q8.8

	////////////////////////////////////////
	// vector and quad bundles
	////////////////////////////////////////
	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
		fix_t w;
	} vec4_t;

	typedef struct packed {
		vec4_t a;
		vec4_t b;
	} dot_req_t;

	// w of each vertex is ignored, the transform forces 1.0
	typedef struct packed {
		vec4_t [NUM_VERTS-1:0] v;
	} world_quad_t;

	// rows 0, 1 and 3 of the view-projection matrix
	typedef struct packed {
		vec4_t row0;
		vec4_t row1;
		vec4_t row3;
	} vp_rows_t;

	typedef struct packed {
		vec4_t normal;	// w zero
		vec4_t light;	// w zero
	} shade_in_t;

	typedef struct packed {
		logic [SCR_W-1:0] x;
		logic [SCR_W-1:0] y;
	} scr_vert_t;

	typedef struct packed {
		scr_vert_t [NUM_VERTS-1:0] v;
	} screen_quad_t;

endpackage

// File: design/dot4_unit.sv
module dot4_unit import vs_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     i_start,
	input  dot_req_t i_req,
	output logic     o_done,
	output fix_t     o_result
);

	logic signed [2*FIX_W-1:0] prod [4];	// q16.16 products
	logic signed [2*FIX_W+1:0] sum;			// two guard bits for the adds
	logic [DOT_LATENCY-1:0] vld;

	// stage 1, four products
	always_ff @(posedge clk) begin
		prod[0] <= i_req.a.x * i_req.b.x;
		prod[1] <= i_req.a.y * i_req.b.y;
		prod[2] <= i_req.a.z * i_req.b.z;
		prod[3] <= i_req.a.w * i_req.b.w;
	end

	// stage 2, full precision sum
	always_ff @(posedge clk) begin
		sum <= prod[0] + prod[1] + prod[2] + prod[3];
	end

	// stage 3, back to q8.8
	// dropping the low bits of a two's complement sum rounds toward minus infinity
	always_ff @(posedge clk) begin
		o_result <= sum[FRAC_BITS +: FIX_W];
	end

	// start travels alongside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			vld <= '0;
		end else begin
			vld <= {vld[DOT_LATENCY-2:0], i_start};
		end
	end

	assign o_done = vld[DOT_LATENCY-1];

endmodule

// File: design/dot_arbiter.sv
module dot_arbiter import vs_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     i_xf_req,		// transform, high priority
	input  dot_req_t i_xf_ops,
	input  logic     i_sh_req,		// face shader
	input  dot_req_t i_sh_ops,
	output logic     o_xf_done,
	output logic     o_sh_done,
	output fix_t     o_result
);

	logic     busy;			// an operation is in flight
	logic     owner_sh;		// 0 transform, 1 shader
	logic     dot_start;
	logic     dot_done;
	dot_req_t dot_ops;

	// the owner holds its operands until its done pulse
	assign dot_ops = owner_sh ? i_sh_ops : i_xf_ops;

	////////////////////////////////////////
	// grant and owner tracking
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			owner_sh  <= 1'b0;
			dot_start <= 1'b0;
		end else begin
			dot_start <= 1'b0;
			if (!busy && (i_xf_req || i_sh_req)) begin
				busy      <= 1'b1;
				owner_sh  <= !i_xf_req;	// transform wins a tie
				dot_start <= 1'b1;
			end else if (dot_done) begin
				// requester still high this cycle, so no regrant until next
				busy <= 1'b0;
			end
		end
	end

	assign o_xf_done = dot_done && !owner_sh;
	assign o_sh_done = dot_done && owner_sh;

	dot4_unit u_dot (
		.clk      (clk),
		.reset    (reset),
		.i_start  (dot_start),
		.i_req    (dot_ops),
		.o_done   (dot_done),
		.o_result (o_result)
	);

endmodule

// File: design/ndc_divider.sv
module ndc_divider import vs_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic i_start,
	input  fix_t i_num,		// q8.8 clip x or y
	input  fix_t i_den,		// q8.8 clip w
	output logic o_done,
	output fix_t o_quot		// q2.14
);

	logic signed [FIX_W:0]   num_ext;
	logic signed [FIX_W:0]   den_ext;
	logic [FIX_W:0]          num_mag;
	logic [FIX_W:0]          den_in_mag;
	logic [FIX_W:0]          den_mag;
	logic [FIX_W:0]          rem;
	logic [FIX_W:0]          rem_shift;
	logic [FIX_W+1:0]        trial;
	logic [DIV_CYCLES-1:0]   quo;
	logic [$clog2(DIV_CYCLES)-1:0] cnt;
	logic busy;
	logic fin;
	logic neg;
	logic den_zero;

	// magnitudes, one extra bit so -32768 fits
	assign num_ext    = i_num;
	assign den_ext    = i_den;
	assign num_mag    = num_ext[FIX_W] ? -num_ext : num_ext;
	assign den_in_mag = den_ext[FIX_W] ? -den_ext : den_ext;

	// restoring step, next dividend bit into the remainder
	assign rem_shift = {rem[FIX_W-1:0], quo[DIV_CYCLES-1]};
	assign trial     = {1'b0, rem_shift} - {1'b0, den_mag};

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			fin    <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin;
			fin    <= 1'b0;
			if (i_start && !busy) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == DIV_CYCLES - 1) begin
					busy <= 1'b0;
					fin  <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (i_start && !busy) begin
			rem      <= '0;
			quo      <= {{(DIV_CYCLES-FIX_W-1){1'b0}}, num_mag} << NDC_FRAC;	// scale by 2^14
			den_mag  <= den_in_mag;
			den_zero <= (i_den == '0);
			neg      <= i_num[FIX_W-1] ^ i_den[FIX_W-1];
		end else if (busy) begin
			if (!trial[FIX_W+1]) begin
				rem <= trial[FIX_W:0];
				quo <= {quo[DIV_CYCLES-2:0], 1'b1};
			end else begin
				rem <= rem_shift;
				quo <= {quo[DIV_CYCLES-2:0], 1'b0};
			end
		end
		if (fin) begin
			// magnitude already truncated, so the signed result rounds toward zero
			if (den_zero)
				o_quot <= '0;
			else if (neg)
				o_quot <= -quo[FIX_W-1:0];
			else
				o_quot <= quo[FIX_W-1:0];
		end
	end

endmodule

// File: design/vertex_transform.sv
module vertex_transform import vs_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         i_pc_data_ready,
	input  world_quad_t  i_world,
	input  vp_rows_t     i_vp,
	output logic         o_dot_req,
	output dot_req_t     o_dot_ops,
	input  logic         i_dot_done,
	input  fix_t         i_dot_result,
	output logic         o_quad_valid,
	output screen_quad_t o_quad
);

	typedef enum logic [1:0] {S_IDLE, S_DOT, S_DIV, S_VIEW} state_e;

	state_e            state;
	logic [VERT_W-1:0] vert;
	logic [1:0]        row;			// 0 x, 1 y, 2 w
	logic [VERT_W:0]   div_idx;		// {vertex, axis}
	world_quad_t       world_q;
	vp_rows_t          vp_q;
	fix_t              clip_x [NUM_VERTS];
	fix_t              clip_y [NUM_VERTS];
	fix_t              clip_w [NUM_VERTS];
	fix_t              ndc_x [NUM_VERTS];
	fix_t              ndc_y [NUM_VERTS];
	vec4_t             vert_h;
	vec4_t             row_sel;
	logic              div_start;
	logic              div_done;
	fix_t              div_num;
	fix_t              div_den;
	fix_t              div_quot;
	logic signed [31:0] scr_x;
	logic signed [31:0] scr_y;

	////////////////////////////////////////
	// dot operands, vertex times matrix row
	////////////////////////////////////////
	always_comb begin
		vert_h   = world_q.v[vert];
		vert_h.w = FIX_ONE;		// homogeneous w
		case (row)
			2'd0:    row_sel = vp_q.row0;
			2'd1:    row_sel = vp_q.row1;
			default: row_sel = vp_q.row3;
		endcase
	end

	assign o_dot_req = (state == S_DOT);
	assign o_dot_ops = '{a: vert_h, b: row_sel};

	// x then y of each vertex over its own w
	assign div_num = div_idx[0] ? clip_y[div_idx[VERT_W:1]] : clip_x[div_idx[VERT_W:1]];
	assign div_den = clip_w[div_idx[VERT_W:1]];

	// viewport, floor(ndc * half / 2^14) + half
	assign scr_x = ((32'(ndc_x[vert]) * HALF_W) >>> NDC_FRAC) + HALF_W;
	assign scr_y = ((32'(ndc_y[vert]) * HALF_H) >>> NDC_FRAC) + HALF_H;

	ndc_divider u_div (
		.clk     (clk),
		.reset   (reset),
		.i_start (div_start),
		.i_num   (div_num),
		.i_den   (div_den),
		.o_done  (div_done),
		.o_quot  (div_quot)
	);

	////////////////////////////////////////
	// sequencer
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= S_IDLE;
			vert         <= '0;
			row          <= '0;
			div_idx      <= '0;
			div_start    <= 1'b0;
			o_quad_valid <= 1'b0;
		end else begin
			div_start    <= 1'b0;
			o_quad_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_pc_data_ready) begin	// dropped while busy
						state <= S_DOT;
						vert  <= '0;
						row   <= '0;
					end
				end
				S_DOT: begin
					if (i_dot_done) begin
						if (row == 2'd2) begin
							row <= '0;
							vert <= vert + 1'b1;	// wraps to 0 after last vertex
							if (vert == VERT_W'(NUM_VERTS - 1)) begin
								state     <= S_DIV;
								div_idx   <= '0;
								div_start <= 1'b1;
							end
						end else begin
							row <= row + 1'b1;
						end
					end
				end
				S_DIV: begin
					if (div_done) begin
						if (div_idx == '1) begin
							state <= S_VIEW;
						end else begin
							div_idx   <= div_idx + 1'b1;
							div_start <= 1'b1;
						end
					end
				end
				S_VIEW: begin
					vert <= vert + 1'b1;	// one vertex per cycle
					if (vert == VERT_W'(NUM_VERTS - 1)) begin
						state        <= S_IDLE;
						o_quad_valid <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// working registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_pc_data_ready) begin
			world_q <= i_world;
			vp_q    <= i_vp;
		end
		if (state == S_DOT && i_dot_done) begin
			case (row)
				2'd0:    clip_x[vert] <= i_dot_result;
				2'd1:    clip_y[vert] <= i_dot_result;
				default: clip_w[vert] <= i_dot_result;
			endcase
		end
		if (state == S_DIV && div_done) begin
			if (div_idx[0])
				ndc_y[div_idx[VERT_W:1]] <= div_quot;
			else
				ndc_x[div_idx[VERT_W:1]] <= div_quot;
		end
		if (state == S_VIEW) begin
			o_quad.v[vert].x <= scr_x[SCR_W-1:0];
			o_quad.v[vert].y <= scr_y[SCR_W-1:0];
		end
	end

endmodule

// File: design/face_shader.sv
module face_shader import vs_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_pc_data_ready,
	input  shade_in_t  i_shade,
	output logic       o_dot_req,
	output dot_req_t   o_dot_ops,
	input  logic       i_dot_done,
	input  fix_t       i_dot_result,
	output logic       o_shade_valid,
	output logic [1:0] o_intensity
);

	typedef enum logic {S_IDLE, S_REQ} state_e;

	state_e     state;
	shade_in_t  shade_q;
	logic [1:0] level;

	assign o_dot_req = (state == S_REQ);
	assign o_dot_ops = '{a: shade_q.normal, b: shade_q.light};

	// 2-bit intensity from n.l, back faces use the magnitude
	always_comb begin
		if (!i_dot_result[FIX_W-1]) begin
			if (i_dot_result >= FIX_ONE)
				level = 2'd3;	// saturate at 1.0
			else
				level = i_dot_result[FRAC_BITS-1 -: 2];
		end else begin
			if (i_dot_result <= -FIX_ONE)
				level = 2'd3;
			else
				level = ~i_dot_result[FRAC_BITS-1 -: 2];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= S_IDLE;
			o_shade_valid <= 1'b0;
		end else begin
			o_shade_valid <= 1'b0;
			case (state)
				S_IDLE:  if (i_pc_data_ready) state <= S_REQ;
				S_REQ: begin
					if (i_dot_done) begin	// request drops next cycle
						state         <= S_IDLE;
						o_shade_valid <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_pc_data_ready)
			shade_q <= i_shade;
		if (state == S_REQ && i_dot_done)
			o_intensity <= level;
	end

endmodule

// File: design/frame_buffer.sv
module frame_buffer import vs_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         i_frame_start,		// start of vertical blanking
	input  logic         i_quad_valid,
	input  screen_quad_t i_quad,
	input  logic         i_shade_valid,
	input  logic [1:0]   i_intensity,
	output screen_quad_t o_quad,
	output logic [1:0]   o_intensity
);

	screen_quad_t quad_slot [2];
	logic [1:0]   int_slot [2];
	logic         wr_sel;		// back slot
	logic         pending;		// a finished quad waits for the strobe

	// shading finishes ahead of the transform, so both land in the same back slot
	always_ff @(posedge clk) begin
		if (i_quad_valid)
			quad_slot[wr_sel] <= i_quad;
		if (i_shade_valid)
			int_slot[wr_sel] <= i_intensity;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_sel      <= 1'b0;
			pending     <= 1'b0;
			o_quad      <= '0;
			o_intensity <= '0;
		end else begin
			if (i_frame_start && pending) begin
				o_quad      <= quad_slot[!wr_sel];	// newest complete slot
				o_intensity <= int_slot[!wr_sel];
				pending     <= 1'b0;
			end
			if (i_quad_valid) begin
				wr_sel  <= !wr_sel;
				pending <= 1'b1;
			end
		end
	end

endmodule

// File: design/vertex_shader_top.sv
module vertex_shader_top import vs_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         i_pc_data_ready,
	input  world_quad_t  i_world,
	input  vp_rows_t     i_vp,
	input  shade_in_t    i_shade,
	input  logic         i_frame_start,
	output screen_quad_t o_quad,
	output logic [1:0]   o_intensity
);

	logic         xf_req;
	dot_req_t     xf_ops;
	logic         xf_done;
	logic         sh_req;
	dot_req_t     sh_ops;
	logic         sh_done;
	fix_t         dot_result;	// shared by both peers
	logic         quad_valid;
	screen_quad_t quad;
	logic         shade_valid;
	logic [1:0]   intensity;

	vertex_transform u_xf (
		.clk             (clk),
		.reset           (reset),
		.i_pc_data_ready (i_pc_data_ready),
		.i_world         (i_world),
		.i_vp            (i_vp),
		.o_dot_req       (xf_req),
		.o_dot_ops       (xf_ops),
		.i_dot_done      (xf_done),
		.i_dot_result    (dot_result),
		.o_quad_valid    (quad_valid),
		.o_quad          (quad)
	);

	face_shader u_sh (
		.clk             (clk),
		.reset           (reset),
		.i_pc_data_ready (i_pc_data_ready),
		.i_shade         (i_shade),
		.o_dot_req       (sh_req),
		.o_dot_ops       (sh_ops),
		.i_dot_done      (sh_done),
		.i_dot_result    (dot_result),
		.o_shade_valid   (shade_valid),
		.o_intensity     (intensity)
	);

	dot_arbiter u_arb (
		.clk       (clk),
		.reset     (reset),
		.i_xf_req  (xf_req),
		.i_xf_ops  (xf_ops),
		.i_sh_req  (sh_req),
		.i_sh_ops  (sh_ops),
		.o_xf_done (xf_done),
		.o_sh_done (sh_done),
		.o_result  (dot_result)
	);

	frame_buffer u_fb (
		.clk           (clk),
		.reset         (reset),
		.i_frame_start (i_frame_start),
		.i_quad_valid  (quad_valid),
		.i_quad        (quad),
		.i_shade_valid (shade_valid),
		.i_intensity   (intensity),
		.o_quad        (o_quad),
		.o_intensity   (o_intensity)
	);

endmodule

// File: dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////
// reference model of the vertex stage
////////////////////////////////////////

// q8.8 dot product, full sum floored back to q8.8
function automatic fix_t mul_add_q88(input vec4_t a, input vec4_t b);
	longint s;
	s = longint'(a.x) * longint'(b.x) + longint'(a.y) * longint'(b.y)
		+ longint'(a.z) * longint'(b.z) + longint'(a.w) * longint'(b.w);
	return fix_t'(s >>> FRAC_BITS);
endfunction

// num * 2^14 / den toward zero, zero divisor gives zero
function automatic fix_t ndc_quotient(input fix_t num, input fix_t den);
	longint n;
	n = longint'(num) * (longint'(1) <<< NDC_FRAC);
	if (den == 0)
		return '0;
	return fix_t'(n / longint'(den));
endfunction

// floor(ndc * half / 2^14) + half
function automatic logic [SCR_W-1:0] to_screen(input fix_t ndc, input int half);
	longint p;
	longint q;
	p = longint'(ndc) * half;
	q = p / (longint'(1) <<< NDC_FRAC);
	if ((p % (longint'(1) <<< NDC_FRAC)) != 0 && p < 0)
		q = q - 1;	// division truncates, floor needs one less
	return SCR_W'(q + half);
endfunction

function automatic screen_quad_t project_quad(input world_quad_t w, input vp_rows_t m);
	screen_quad_t q;
	vec4_t        vtx;
	fix_t         cx;
	fix_t         cy;
	fix_t         cw;
	int           i;
	for (i = 0; i < NUM_VERTS; i++) begin
		vtx   = w.v[VERT_W'(i)];
		vtx.w = FIX_ONE;	// world points are homogeneous
		cx    = mul_add_q88(vtx, m.row0);
		cy    = mul_add_q88(vtx, m.row1);
		cw    = mul_add_q88(vtx, m.row3);
		q.v[VERT_W'(i)].x = to_screen(ndc_quotient(cx, cw), HALF_W);
		q.v[VERT_W'(i)].y = to_screen(ndc_quotient(cy, cw), HALF_H);
	end
	return q;
endfunction

// n.l quantized to 2 bits, magnitude for back faces
function automatic logic [1:0] shade_level(input shade_in_t s);
	fix_t d;
	d = mul_add_q88(s.normal, s.light);
	if (d >= 0) begin
		if (d >= FIX_ONE)
			return 2'd3;
		return d[7:6];
	end
	if (d <= -FIX_ONE)
		return 2'd3;
	return ~d[7:6];
endfunction

`endif

// File: dv/tb_vertex_shader.sv
module tb_vertex_shader import vs_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED           = 32'h139c8fd1;
	localparam int RESET_CYCLES   = 4;
	localparam int SETTLE_CYCLES  = 400;	// transform bound is under this
	localparam int NUM_RANDOM     = 40;
	localparam int NUM_TESTS      = NUM_RANDOM + 5;	// three directed and two back to back
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 450 + 100;

	logic         clk;
	logic         reset;
	logic         pc_data_ready;
	world_quad_t  world;
	vp_rows_t     vp;
	shade_in_t    shade;
	logic         frame_start;
	screen_quad_t dut_quad;
	logic [1:0]   dut_int;

	world_quad_t  cur_world;
	vp_rows_t     cur_vp;
	shade_in_t    cur_shade;
	screen_quad_t exp_quad;		// what the outputs should show now
	logic [1:0]   exp_int;
	int           quad_errs;
	int           int_errs;
	int           cycle_cnt;
	int           n;

	`include "tb_model.svh"

	vertex_shader_top u_dut (
		.clk             (clk),
		.reset           (reset),
		.i_pc_data_ready (pc_data_ready),
		.i_world         (world),
		.i_vp            (vp),
		.i_shade         (shade),
		.i_frame_start   (frame_start),
		.o_quad          (dut_quad),
		.o_intensity     (dut_int)
	);

	always #4 clk = ~clk;	// 8 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("simulation timed out after %0d cycles", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////
	function automatic fix_t rand_fix(input int lim);
		return fix_t'(int'($urandom_range(2 * lim)) - lim);
	endfunction

	function automatic world_quad_t rand_world();
		world_quad_t q;
		int          i;
		for (i = 0; i < NUM_VERTS; i++) begin
			q.v[VERT_W'(i)].x = rand_fix(256);	// within +-1.0
			q.v[VERT_W'(i)].y = rand_fix(256);
			q.v[VERT_W'(i)].z = rand_fix(256);
			q.v[VERT_W'(i)].w = rand_fix(256);	// ignored by the transform
		end
		return q;
	endfunction

	// small x/y rows and a dominant w keep |x|, |y| < w
	function automatic vp_rows_t rand_rows();
		vp_rows_t m;
		m.row0.x = rand_fix(96);
		m.row0.y = rand_fix(96);
		m.row0.z = rand_fix(96);
		m.row0.w = rand_fix(96);
		m.row1.x = rand_fix(96);
		m.row1.y = rand_fix(96);
		m.row1.z = rand_fix(96);
		m.row1.w = rand_fix(96);
		m.row3.x = rand_fix(16);
		m.row3.y = rand_fix(16);
		m.row3.z = rand_fix(16);
		m.row3.w = fix_t'(512 + int'($urandom_range(512)));	// 2.0 to 4.0
		return m;
	endfunction

	function automatic shade_in_t rand_shade();
		shade_in_t s;
		s.normal.x = rand_fix(128);	// |c| <= 0.5
		s.normal.y = rand_fix(128);
		s.normal.z = rand_fix(128);
		s.normal.w = '0;
		s.light.x  = rand_fix(128);
		s.light.y  = rand_fix(128);
		s.light.z  = rand_fix(128);
		s.light.w  = '0;
		return s;
	endfunction

	task automatic next_cycle(input int cnt);
		repeat (cnt) @(posedge clk);
		#1;
	endtask

	task automatic send_quad(input world_quad_t w, input vp_rows_t m, input shade_in_t s);
		world         = w;
		vp            = m;
		shade         = s;
		pc_data_ready = 1'b1;
		next_cycle(1);
		pc_data_ready = 1'b0;
		next_cycle(SETTLE_CYCLES);
	endtask

	task automatic strobe_frame();
		frame_start = 1'b1;
		next_cycle(1);
		frame_start = 1'b0;
		next_cycle(1);
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_quad(input screen_quad_t got, input screen_quad_t exp,
			input string tag);
		int i;
		for (i = 0; i < NUM_VERTS; i++) begin
			if (got.v[VERT_W'(i)].x !== exp.v[VERT_W'(i)].x) begin
				$display("ERROR %0t: %s vertex %0d x is %0d, expected %0d", $time, tag, i,
					got.v[VERT_W'(i)].x, exp.v[VERT_W'(i)].x);
				quad_errs++;
			end
			if (got.v[VERT_W'(i)].y !== exp.v[VERT_W'(i)].y) begin
				$display("ERROR %0t: %s vertex %0d y is %0d, expected %0d", $time, tag, i,
					got.v[VERT_W'(i)].y, exp.v[VERT_W'(i)].y);
				quad_errs++;
			end
		end
	endtask

	task automatic check_intensity(input logic [1:0] got, input logic [1:0] exp,
			input string tag);
		if (got !== exp) begin
			$display("ERROR %0t: %s intensity is %0d, expected %0d", $time, tag, got, exp);
			int_errs++;
		end
	endtask

	// outputs must hold until the strobe, then show the new quad
	task automatic run_frame(input string tag);
		send_quad(cur_world, cur_vp, cur_shade);
		check_quad(dut_quad, exp_quad, {tag, " before strobe"});
		check_intensity(dut_int, exp_int, {tag, " before strobe"});
		strobe_frame();
		exp_quad = project_quad(cur_world, cur_vp);
		exp_int  = shade_level(cur_shade);
		check_quad(dut_quad, exp_quad, tag);
		check_intensity(dut_int, exp_int, tag);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		pc_data_ready = 1'b0;
		frame_start   = 1'b0;
		world         = '0;
		vp            = '0;
		shade         = '0;
		quad_errs     = 0;
		int_errs      = 0;
		cycle_cnt     = 0;
		void'($urandom(SEED));
		next_cycle(RESET_CYCLES);
		reset = 1'b0;
		next_cycle(2);

		exp_quad = '0;
		exp_int  = '0;
		check_quad(dut_quad, exp_quad, "after reset");
		check_intensity(dut_int, exp_int, "after reset");

		for (n = 0; n < NUM_RANDOM; n++) begin
			cur_world = rand_world();
			cur_vp    = rand_rows();
			cur_shade = rand_shade();
			run_frame($sformatf("random quad %0d", n));
		end

		// saturation at exactly +1.0 and -1.0 and past -1.0
		cur_world      = rand_world();
		cur_vp         = rand_rows();
		cur_shade      = '0;
		cur_shade.normal.x = FIX_ONE;
		cur_shade.light.x  = FIX_ONE;
		run_frame("front face d=+1.0");
		check_intensity(dut_int, 2'd3, "front face d=+1.0 saturated");
		cur_world      = rand_world();
		cur_shade.light.x  = -FIX_ONE;
		run_frame("back face d=-1.0");
		check_intensity(dut_int, 2'd3, "back face d=-1.0 saturated");
		cur_world         = rand_world();
		cur_shade.light.x = fix_t'(-320);	// -1.25, low bits alone would give 0
		run_frame("back face d=-1.25");
		check_intensity(dut_int, 2'd3, "back face d=-1.25 saturated");

		// only the second of two quads shows at the strobe
		cur_world = rand_world();
		cur_vp    = rand_rows();
		cur_shade = rand_shade();
		send_quad(cur_world, cur_vp, cur_shade);
		check_quad(dut_quad, exp_quad, "first of pair before strobe");
		check_intensity(dut_int, exp_int, "first of pair before strobe");
		cur_world = rand_world();
		cur_vp    = rand_rows();
		cur_shade = rand_shade();
		run_frame("second of pair");

		$display("errors: quad %0d, intensity %0d", quad_errs, int_errs);
		if (quad_errs == 0 && int_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+dv
design/vs_pkg.sv
design/dot4_unit.sv
design/dot_arbiter.sv
design/ndc_divider.sv
design/vertex_transform.sv
design/face_shader.sv
design/frame_buffer.sv
design/vertex_shader_top.sv
dv/tb_vertex_shader.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vertex stage testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -sv --timescale 1ns/1ps -f build.f --top-module tb_vertex_shader \
	-o tb_vertex_shader > sim.log 2>&1 \
	&& ./obj_dir/tb_vertex_shader >> sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
cat sim.log
! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log
